/* build.f */
rtl/exeOpsPkg.sv
rtl/exeExcPkg.sv
rtl/exeReg.sv
rtl/forwardUnit.sv
rtl/alu.sv
rtl/mulDiv.sv
rtl/branchExcept.sv
rtl/memReg.sv
rtl/exeStage.sv
verification/tbExeStage.sv

/* verification/tbExeStage.sv */
// directed testbench for the execute stage: reference model, compare tasks, watchdog
module tbExeStage import exeOpsPkg::*, exeExcPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int ALU_RUNS   = 24;
    localparam int NUM_TESTS  = ALU_RUNS + 3 + 21 + 5 + 6 + 3; // one per checked instruction

    logic            clk;
    logic            rst;
    logic            exeWr;
    logic            exeFlush;
    logic [XLEN-1:0] idPc;
    logic [XLEN-1:0] idBusA;
    logic [XLEN-1:0] idBusB;
    logic [XLEN-1:0] idImm32;
    logic [4:0]      idRs;
    logic [4:0]      idRt;
    logic [4:0]      idRd;
    logic [4:0]      idShamt;
    aluOpT           idAluOp;
    logic            idSrcA;
    logic            idSrcB;
    dstSelT          idDstSel;
    logic            idRegWr;
    memOpT           idMemOp;
    branchT          idBranch;
    trapT            idTrap;
    logic            wbRegWr;
    logic [4:0]      wbDst;
    logic [XLEN-1:0] wbResult;
    logic [XLEN-1:0] memAluOut;
    logic [XLEN-1:0] memBusB;
    logic [4:0]      memDst;
    logic            memRegWr;
    memOpT           memMemOp;
    excT             memExc;
    logic            branchFlush;
    logic [XLEN-1:0] branchTarget;
    logic            mulDivStall;
    integer          seed;

    exeStage exeStage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 40 * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        stopOnError();
    end

    task automatic stopOnError();
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic checkResult(input string name, input logic [XLEN-1:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkDst(input string name, input logic [4:0] got, exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkExc(input string name, input excT got, exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkMemOp(input string name, input memOpT got, exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkFlag(input string name, input logic got, exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            stopOnError();
        end
    endtask

    task automatic checkBranch(input logic expFlush, input logic [XLEN-1:0] expTarget);
        checkFlag("branchFlush", branchFlush, expFlush);
        checkResult("branchTarget", branchTarget, expTarget);
    endtask

    function automatic logic [XLEN-1:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [XLEN-1:0] aluRef(aluOpT op, logic [XLEN-1:0] a, b);
        case (op)
            aluAdd, aluAddu: return a + b;
            aluSub, aluSubu: return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluNor:  return ~(a | b);
            aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: return (a < b) ? 32'd1 : 32'd0;
            aluSll:  return b << a[4:0]; // shift amount from A
            aluSrl:  return b >> a[4:0];
            aluSra:  return $signed(b) >>> a[4:0];
            aluLui:  return {b[15:0], 16'h0000};
            default: return '0;
        endcase
    endfunction

    function automatic logic overflowRef(aluOpT op, logic [XLEN-1:0] a, b);
        logic [XLEN-1:0] r;
        if (op == aluAdd) begin
            r = a + b;
            return (a[XLEN-1] == b[XLEN-1]) && (r[XLEN-1] != a[XLEN-1]);
        end else if (op == aluSub) begin
            r = a - b;
            return (a[XLEN-1] != b[XLEN-1]) && (r[XLEN-1] != a[XLEN-1]);
        end
        return 1'b0;
    endfunction

    // returns {hi, lo}
    function automatic logic [2*XLEN-1:0] mulDivRef(aluOpT op, logic [XLEN-1:0] a, b);
        longint          sp;
        longint unsigned up;
        int              sa;
        int              sb;
        sa = a;
        sb = b;
        case (op)
            aluMult: begin
                sp = sa;
                return sp * sb;
            end
            aluMultu: begin
                up = a;
                return up * b;
            end
            aluDiv:  return {sa % sb, sa / sb}; // remainder keeps dividend sign
            aluDivu: return {a % b, a / b};
            default: return '0;
        endcase
    endfunction

    function automatic logic branchTaken(branchT br, logic [XLEN-1:0] a, b);
        case (br)
            brBeq:   return a == b;
            brBne:   return a != b;
            brBlez:  return $signed(a) <= 0;
            brBgtz:  return $signed(a) > 0;
            brBltz:  return $signed(a) < 0;
            brBgez:  return $signed(a) >= 0;
            brJr:    return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1; // drive point
    endtask

    task automatic issue(input aluOpT op, input logic [4:0] rs, rt, rd,
                         input logic [XLEN-1:0] a, b);
        idAluOp  = op;
        idRs     = rs;
        idRt     = rt;
        idRd     = rd;
        idBusA   = a;
        idBusB   = b;
        idPc     = '0;
        idImm32  = '0;
        idShamt  = '0;
        idSrcA   = 1'b0;
        idSrcB   = 1'b0;
        idDstSel = dstRd;
        idRegWr  = 1'b1;
        idMemOp  = memNone;
        idBranch = brNone;
        idTrap   = trapNone;
    endtask

    task automatic bubble();
        issue(aluNop, 5'd0, 5'd0, 5'd0, '0, '0);
        idRegWr = 1'b0;
    endtask

    task automatic waitStallLow();
        int n;
        n = 0;
        while (mulDivStall) begin
            nextCycle();
            n++;
            if (n > 40) begin
                $display("mulDivStall stayed high for more than 40 cycles");
                stopOnError();
            end
        end
    endtask

    task automatic readHiLo(input logic [XLEN-1:0] expHi, expLo);
        issue(aluMfhi, 5'd0, 5'd0, 5'd11, '0, '0);
        nextCycle();
        issue(aluMflo, 5'd0, 5'd0, 5'd12, '0, '0);
        nextCycle();
        checkResult("memAluOut (mfhi)", memAluOut, expHi);
        bubble();
        nextCycle();
        checkResult("memAluOut (mflo)", memAluOut, expLo);
    endtask

    task automatic aluTest();
        aluOpT           ops [14];
        aluOpT           op;
        dstSelT          sel;
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] srcA;
        logic [XLEN-1:0] srcB;
        logic [4:0]      expDst;
        logic            ovf;
        ops = '{aluAdd, aluAddu, aluSub, aluSubu, aluAnd, aluOr, aluXor, aluNor,
                aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui};
        for (int i = 0; i < ALU_RUNS; i++) begin
            r   = rand32();
            a   = rand32();
            b   = rand32();
            imm = rand32();
            op  = ops[r[31:19] % 14];
            sel = (r[18:17] == 2'd3) ? dstRd : dstSelT'(r[18:17]);
            srcA = r[15] ? {27'b0, r[14:10]} : a;
            srcB = r[16] ? imm : b;
            ovf  = overflowRef(op, srcA, srcB);
            expDst = (sel == dstRt) ? r[9:5] : ((sel == dstLink) ? 5'd31 : r[4:0]);
            issue(op, 5'd1, r[9:5], r[4:0], a, b);
            idShamt  = r[14:10];
            idSrcA   = r[15];
            idSrcB   = r[16];
            idImm32  = imm;
            idDstSel = sel;
            nextCycle();
            bubble();
            nextCycle();
            checkResult("memAluOut", memAluOut, aluRef(op, srcA, srcB));
            checkDst("memDst", memDst, expDst);
            checkExc("memExc", memExc, ovf ? excOverflow : excNone);
            checkFlag("memRegWr", memRegWr, !ovf);
        end
    endtask

    task automatic forwardTest();
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        logic [XLEN-1:0] z;
        x = rand32();
        y = rand32();
        z = rand32();
        // dependent pair with a stale writeback value for r7
        issue(aluAddu, 5'd1, 5'd2, 5'd7, x, y);
        nextCycle();
        issue(aluAddu, 5'd7, 5'd3, 5'd8, 32'hdead_0000, z);
        nextCycle();
        checkResult("memAluOut", memAluOut, x + y);
        bubble();
        wbRegWr  = 1'b1;
        wbDst    = 5'd7;
        wbResult = 32'h5555_aaaa;
        nextCycle();
        checkResult("memAluOut", memAluOut, x + y + z);
        issue(aluAddu, 5'd9, 5'd10, 5'd11, 32'hbad0_0000, y);
        wbRegWr = 1'b0;
        nextCycle();
        bubble();
        wbRegWr  = 1'b1;
        wbDst    = 5'd9;
        wbResult = z;
        nextCycle();
        wbRegWr = 1'b0;
        checkResult("memAluOut", memAluOut, z + y);
        // writes to r0 never bypass
        issue(aluAddu, 5'd1, 5'd2, 5'd0, x, y);
        nextCycle();
        issue(aluAddu, 5'd0, 5'd0, 5'd12, '0, '0);
        idSrcB  = 1'b1;
        idImm32 = 32'h55;
        nextCycle();
        bubble();
        wbRegWr  = 1'b1;
        wbDst    = 5'd0;
        wbResult = 32'hffff_ffff;
        nextCycle();
        wbRegWr = 1'b0;
        checkResult("memAluOut", memAluOut, 32'h55);
        checkDst("memDst", memDst, 5'd12);
    endtask

    task automatic branchTest();
        logic [XLEN-1:0] aVals [3];
        logic [XLEN-1:0] bVals [3];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] target;
        branchT          br;
        aVals = '{32'h0000_0000, 32'h7fff_0000, 32'hffff_fff0};
        bVals = '{32'h0000_0000, 32'h7fff_0001, 32'hffff_fff0};
        for (int k = 1; k < 8; k++) begin
            for (int j = 0; j < 3; j++) begin
                br  = branchT'(k);
                pc  = rand32() & 32'hffff_fffc;
                imm = rand32();
                imm = {{16{imm[15]}}, imm[15:0]};
                target = (br == brJr) ? aVals[j] : pc + 32'd4 + (imm << 2);
                issue(aluNop, 5'd1, 5'd2, 5'd0, aVals[j], bVals[j]);
                idRegWr  = 1'b0;
                idBranch = br;
                idPc     = pc;
                idImm32  = imm;
                nextCycle();
                bubble();
                #2;
                checkBranch(branchTaken(br, aVals[j], bVals[j]), target);
                nextCycle();
            end
        end
    endtask

    task automatic mulDivTest();
        aluOpT           ops [4];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [2*XLEN-1:0] expHiLo;
        ops = '{aluMult, aluMultu, aluDiv, aluDivu};
        for (int i = 0; i < 4; i++) begin
            a = rand32();
            b = rand32();
            if (b == '0 || b == '1)
                b = 32'h0000_0007; // no divide by zero or min/-1
            expHiLo = mulDivRef(ops[i], a, b);
            issue(ops[i], 5'd1, 5'd2, 5'd0, a, b);
            idRegWr = 1'b0;
            nextCycle();
            checkFlag("mulDivStall", mulDivStall, 1'b1);
            bubble();
            waitStallLow();
            readHiLo(expHiLo[2*XLEN-1:XLEN], expHiLo[XLEN-1:0]);
        end
        a = rand32();
        b = rand32();
        issue(aluMthi, 5'd3, 5'd0, 5'd0, a, '0);
        idRegWr = 1'b0;
        nextCycle();
        issue(aluMtlo, 5'd4, 5'd0, 5'd0, b, '0);
        idRegWr = 1'b0;
        nextCycle();
        readHiLo(a, b);
    endtask

    task automatic expectException(input excT expExc, input memOpT expOp);
        nextCycle();
        bubble();
        nextCycle();
        checkExc("memExc", memExc, expExc);
        checkMemOp("memMemOp", memMemOp, expOp);
        checkFlag("memRegWr", memRegWr, 1'b0);
    endtask

    task automatic exceptionTest();
        issue(aluAdd, 5'd1, 5'd2, 5'd6, 32'h7fff_ffff, 32'h0000_0001);
        expectException(excOverflow, memNone);
        issue(aluSubu, 5'd1, 5'd0, 5'd0, 32'h0000_1234, '0);
        idRegWr = 1'b0;
        idTrap  = trapTeq;
        idSrcB  = 1'b1;
        idImm32 = 32'h0000_1234;
        expectException(excTrap, memNone);
        issue(aluSubu, 5'd1, 5'd0, 5'd0, 32'h0000_1234, '0);
        idRegWr = 1'b0;
        idTrap  = trapTne;
        idSrcB  = 1'b1;
        idImm32 = 32'h0000_1235;
        expectException(excTrap, memNone);
        issue(aluAdd, 5'd1, 5'd7, 5'd0, 32'h0000_1000, '0); // lw at 0x1002
        idDstSel = dstRt;
        idSrcB   = 1'b1;
        idImm32  = 32'd2;
        idMemOp  = memLw;
        expectException(excAddrLoad, memNone);
        issue(aluAdd, 5'd1, 5'd2, 5'd0, 32'h0000_2000, 32'h0000_beef); // sh at 0x2001
        idRegWr = 1'b0;
        idSrcB  = 1'b1;
        idImm32 = 32'd1;
        idMemOp = memSh;
        expectException(excAddrStore, memNone);
        issue(aluAdd, 5'd1, 5'd2, 5'd0, 32'h0000_2000, 32'hcafe_0001);
        idRegWr = 1'b0;
        idSrcB  = 1'b1;
        idImm32 = 32'd4;
        idMemOp = memSw;
        expectException(excNone, memSw);
        checkResult("memBusB", memBusB, 32'hcafe_0001);
    endtask

    task automatic controlTest();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = rand32();
        b = rand32();
        // flush kills execute and ignores decode
        issue(aluAddu, 5'd1, 5'd2, 5'd4, a, b);
        idMemOp = memLb;
        nextCycle();
        issue(aluAddu, 5'd1, 5'd2, 5'd5, b, b);
        exeFlush = 1'b1;
        nextCycle();
        exeFlush = 1'b0;
        bubble();
        checkFlag("memRegWr", memRegWr, 1'b0);
        checkMemOp("memMemOp", memMemOp, memNone);
        nextCycle();
        checkFlag("memRegWr", memRegWr, 1'b0);
        // exeWr low holds execute
        issue(aluAddu, 5'd1, 5'd2, 5'd5, a, b);
        nextCycle();
        exeWr = 1'b0;
        issue(aluXor, 5'd1, 5'd2, 5'd6, b, a);
        nextCycle();
        checkFlag("memRegWr", memRegWr, 1'b0);
        exeWr = 1'b1;
        bubble();
        nextCycle();
        checkResult("memAluOut", memAluOut, a + b);
        checkDst("memDst", memDst, 5'd5);
        checkFlag("memRegWr", memRegWr, 1'b1);
        // reset clears controls and HI/LO
        issue(aluAddu, 5'd1, 5'd2, 5'd5, a, b);
        idMemOp  = memLb;
        idBranch = brJr;
        nextCycle();
        rst = 1'b1;
        idAluOp = aluDivu; // div and jr held in decode
        nextCycle();
        rst = 1'b0;
        bubble();
        checkFlag("memRegWr", memRegWr, 1'b0);
        checkMemOp("memMemOp", memMemOp, memNone);
        checkFlag("mulDivStall", mulDivStall, 1'b0);
        #2;
        checkFlag("branchFlush", branchFlush, 1'b0);
        nextCycle();
        readHiLo('0, '0);
    endtask

    initial begin
        seed     = 32'hbe4a_ce88;
        rst      = 1'b1;
        exeWr    = 1'b1;
        exeFlush = 1'b0;
        wbRegWr  = 1'b0;
        wbDst    = '0;
        wbResult = '0;
        bubble();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        aluTest();
        forwardTest();
        branchTest();
        mulDivTest();
        exceptionTest();
        controlTest();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* rtl/exeStage.sv */
// execute stage top: pipeline registers, bypass, ALU, mul/div, branch and exceptions
module exeStage import exeOpsPkg::*, exeExcPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            exeWr,
    input  logic            exeFlush,
    input  logic [XLEN-1:0] idPc,
    input  logic [XLEN-1:0] idBusA,
    input  logic [XLEN-1:0] idBusB,
    input  logic [XLEN-1:0] idImm32,
    input  logic [4:0]      idRs,
    input  logic [4:0]      idRt,
    input  logic [4:0]      idRd,
    input  logic [4:0]      idShamt,
    input  aluOpT           idAluOp,
    input  logic            idSrcA,
    input  logic            idSrcB,
    input  dstSelT          idDstSel,
    input  logic            idRegWr,
    input  memOpT           idMemOp,
    input  branchT          idBranch,
    input  trapT            idTrap,
    input  logic            wbRegWr,
    input  logic [4:0]      wbDst,
    input  logic [XLEN-1:0] wbResult,
    output logic [XLEN-1:0] memAluOut,
    output logic [XLEN-1:0] memBusB,
    output logic [4:0]      memDst,
    output logic            memRegWr,
    output memOpT           memMemOp,
    output excT             memExc,
    output logic            branchFlush,
    output logic [XLEN-1:0] branchTarget,
    output logic            mulDivStall
);

    logic            hold;
    logic            memStall;
    logic [XLEN-1:0] exePc;
    logic [XLEN-1:0] exeBusA;
    logic [XLEN-1:0] exeBusB;
    logic [XLEN-1:0] exeImm32;
    logic [4:0]      exeRs;
    logic [4:0]      exeRt;
    logic [4:0]      exeRd;
    logic [4:0]      exeShamt;
    aluOpT           exeAluOp;
    logic            exeSrcA;
    logic            exeSrcB;
    dstSelT          exeDstSel;
    logic            exeRegWr;
    memOpT           exeMemOp;
    branchT          exeBranch;
    trapT            exeTrap;
    logic [4:0]      exeDst;
    logic [XLEN-1:0] fwdA;
    logic [XLEN-1:0] fwdB;
    logic [XLEN-1:0] hi;
    logic [XLEN-1:0] lo;
    logic [XLEN-1:0] aluOut;
    logic            overflow;
    excT             exc;

    assign hold     = !exeWr || mulDivStall;
    assign memStall = hold || exeFlush; // held or killed instr leaves a bubble

    always_comb begin
        case (exeDstSel)
            dstRt:   exeDst = exeRt;
            dstLink: exeDst = LINK_REG;
            default: exeDst = exeRd;
        endcase
    end

    exeReg exeReg_inst (.*);

    forwardUnit forwardUnit_inst (.*);

    alu alu_inst (.*);

    mulDiv mulDiv_inst (.*);

    branchExcept branchExcept_inst (.*);

    memReg memReg_inst (.*, .stall(memStall));

endmodule

/* rtl/memReg.sv */
// execute-to-memory register with bubble insertion and exception kill
module memReg import exeOpsPkg::*, exeExcPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic [XLEN-1:0] aluOut,
    input  logic [XLEN-1:0] fwdB,
    input  logic [4:0]      exeDst,
    input  logic            exeRegWr,
    input  memOpT           exeMemOp,
    input  excT             exc,
    output logic [XLEN-1:0] memAluOut,
    output logic [XLEN-1:0] memBusB,
    output logic [4:0]      memDst,
    output logic            memRegWr,
    output memOpT           memMemOp,
    output excT             memExc
);

    always_ff @(posedge clk) begin
        memAluOut <= aluOut;
        memBusB   <= fwdB; // store data
        memDst    <= exeDst;
    end

    always_ff @(posedge clk) begin
        if (rst || stall) begin
            memRegWr <= 1'b0;
            memMemOp <= memNone;
            memExc   <= excNone;
        end else begin
            memRegWr <= exeRegWr && (exc == excNone);
            memMemOp <= (exc == excNone) ? exeMemOp : memNone;
            memExc   <= exc;
        end
    end

endmodule

/* rtl/branchExcept.sv */
// branch compare and target, trap test, address alignment and exception priority
module branchExcept import exeOpsPkg::*, exeExcPkg::*; (
    input  logic [XLEN-1:0] exePc,
    input  logic [XLEN-1:0] exeImm32,
    input  branchT          exeBranch,
    input  trapT            exeTrap,
    input  memOpT           exeMemOp,
    input  logic [XLEN-1:0] fwdA,
    input  logic [XLEN-1:0] fwdB,
    input  logic [XLEN-1:0] aluOut,
    input  logic            overflow,
    output logic            branchFlush,
    output logic [XLEN-1:0] branchTarget,
    output excT             exc
);

    logic trapHit;
    logic misLoad;
    logic misStore;

    always_comb begin
        case (exeBranch)
            brBeq:   branchFlush = (fwdA == fwdB);
            brBne:   branchFlush = (fwdA != fwdB);
            brBlez:  branchFlush = fwdA[XLEN-1] || (fwdA == '0);
            brBgtz:  branchFlush = !fwdA[XLEN-1] && (fwdA != '0);
            brBltz:  branchFlush = fwdA[XLEN-1];
            brBgez:  branchFlush = !fwdA[XLEN-1];
            brJr:    branchFlush = 1'b1;
            default: branchFlush = 1'b0;
        endcase
    end

    assign branchTarget = (exeBranch == brJr) ? fwdA
                        : exePc + XLEN'(4) + {exeImm32[XLEN-3:0], 2'b00};

    // traps issue subu, so aluOut is A minus the selected operand
    assign trapHit = (exeTrap == trapTeq && aluOut == '0) || (exeTrap == trapTne && aluOut != '0);

    assign misLoad  = (exeMemOp == memLw && aluOut[1:0] != 2'b00)
                   || ((exeMemOp == memLh || exeMemOp == memLhu) && aluOut[0]);
    assign misStore = (exeMemOp == memSw && aluOut[1:0] != 2'b00)
                   || (exeMemOp == memSh && aluOut[0]);

    assign exc = overflow ? excOverflow
               : trapHit  ? excTrap
               : misLoad  ? excAddrLoad
               : misStore ? excAddrStore
               : excNone;

endmodule

/* rtl/mulDiv.sv */
// multiply/divide sequencer with the HI/LO registers
module mulDiv import exeOpsPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            exeFlush,
    input  logic [XLEN-1:0] fwdA,
    input  logic [XLEN-1:0] fwdB,
    input  aluOpT           exeAluOp,
    output logic [XLEN-1:0] hi,
    output logic [XLEN-1:0] lo,
    output logic            mulDivStall
);

    typedef enum logic [1:0] {stIdle, stMul, stDiv} stateT;

    stateT             state;
    logic              isMul;
    logic              isDiv;
    logic              sgn;
    logic              divLast;
    logic [4:0]        cnt;
    logic [2*XLEN-1:0] prod;
    logic [XLEN-1:0]   quo;
    logic [XLEN-1:0]   rem;
    logic [XLEN-1:0]   dvsr;
    logic              negQ;
    logic              negR;
    logic [XLEN:0]     shifted;
    logic [XLEN+1:0]   trial;
    logic              fits;
    logic [XLEN-1:0]   nextRem;
    logic [XLEN-1:0]   nextQuo;

    assign isMul   = (exeAluOp == aluMult) || (exeAluOp == aluMultu);
    assign isDiv   = (exeAluOp == aluDiv) || (exeAluOp == aluDivu);
    assign sgn     = (exeAluOp == aluMult) || (exeAluOp == aluDiv);
    assign divLast = (state == stDiv) && (cnt == 5'(XLEN - 1));

    // restoring step producing one quotient bit
    assign shifted = {rem, quo[XLEN-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dvsr};
    assign fits    = !trial[XLEN+1];
    assign nextRem = fits ? trial[XLEN-1:0] : shifted[XLEN-1:0];
    assign nextQuo = {quo[XLEN-2:0], fits};

    assign mulDivStall = (state == stIdle && (isMul || isDiv)) || (state == stDiv && !divLast);

    always_ff @(posedge clk) begin
        if (rst || exeFlush) begin
            state <= stIdle; // aborts a running op
        end else begin
            case (state)
                stIdle: state <= isMul ? stMul : (isDiv ? stDiv : stIdle);
                stMul:  state <= stIdle;
                stDiv:  state <= divLast ? stIdle : stDiv;
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == stIdle) begin // capture operands on the start cycle
            prod <= {{XLEN{sgn & fwdA[XLEN-1]}}, fwdA}
                  * {{XLEN{sgn & fwdB[XLEN-1]}}, fwdB};
            quo  <= (sgn && fwdA[XLEN-1]) ? -fwdA : fwdA;
            dvsr <= (sgn && fwdB[XLEN-1]) ? -fwdB : fwdB;
            rem  <= '0;
            cnt  <= '0;
            negQ <= sgn && (fwdA[XLEN-1] ^ fwdB[XLEN-1]);
            negR <= sgn && fwdA[XLEN-1]; // remainder takes dividend sign
        end else if (state == stDiv) begin
            quo <= nextQuo;
            rem <= nextRem;
            cnt <= cnt + 5'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hi <= '0;
            lo <= '0;
        end else if (!exeFlush) begin
            if (state == stMul) begin
                hi <= prod[2*XLEN-1:XLEN];
                lo <= prod[XLEN-1:0];
            end else if (divLast) begin
                hi <= negR ? -nextRem : nextRem;
                lo <= negQ ? -nextQuo : nextQuo;
            end else if (state == stIdle && exeAluOp == aluMthi) begin
                hi <= fwdA;
            end else if (state == stIdle && exeAluOp == aluMtlo) begin
                lo <= fwdA;
            end
        end
    end

endmodule

/* rtl/alu.sv */
// operand select, arithmetic/logic/shift ops, overflow and HI/LO reads
module alu import exeOpsPkg::*; (
    input  logic [XLEN-1:0] fwdA,
    input  logic [XLEN-1:0] fwdB,
    input  logic [XLEN-1:0] exeImm32,
    input  logic [4:0]      exeShamt,
    input  logic            exeSrcA,
    input  logic            exeSrcB,
    input  aluOpT           exeAluOp,
    input  logic [XLEN-1:0] hi,
    input  logic [XLEN-1:0] lo,
    output logic [XLEN-1:0] aluOut,
    output logic            overflow
);

    logic [XLEN-1:0] srcA;
    logic [XLEN-1:0] srcB;
    logic [XLEN:0]   sum;  // one extra sign bit
    logic [XLEN:0]   diff;

    assign srcA = exeSrcA ? {{(XLEN-5){1'b0}}, exeShamt} : fwdA;
    assign srcB = exeSrcB ? exeImm32 : fwdB;
    assign sum  = {srcA[XLEN-1], srcA} + {srcB[XLEN-1], srcB};
    assign diff = {srcA[XLEN-1], srcA} - {srcB[XLEN-1], srcB};

    always_comb begin
        overflow = 1'b0;
        case (exeAluOp)
            aluAdd: begin
                aluOut   = sum[XLEN-1:0];
                overflow = sum[XLEN] ^ sum[XLEN-1];
            end
            aluSub: begin
                aluOut   = diff[XLEN-1:0];
                overflow = diff[XLEN] ^ diff[XLEN-1];
            end
            aluAddu: aluOut = sum[XLEN-1:0];
            aluSubu: aluOut = diff[XLEN-1:0];
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            aluXor:  aluOut = srcA ^ srcB;
            aluNor:  aluOut = ~(srcA | srcB);
            aluSlt:  aluOut = {{(XLEN-1){1'b0}}, diff[XLEN]}; // sign of wide diff
            aluSltu: aluOut = {{(XLEN-1){1'b0}}, srcA < srcB};
            aluSll:  aluOut = srcB << srcA[4:0];
            aluSrl:  aluOut = srcB >> srcA[4:0];
            aluSra:  aluOut = $signed(srcB) >>> srcA[4:0];
            aluLui:  aluOut = {srcB[15:0], 16'h0000};
            aluMfhi: aluOut = hi;
            aluMflo: aluOut = lo;
            aluMthi, aluMtlo: aluOut = srcA;
            default: aluOut = '0;
        endcase
    end

endmodule

/* rtl/forwardUnit.sv */
// operand bypass from the memory stage and the writeback port
module forwardUnit import exeOpsPkg::*; (
    input  logic [4:0]      exeRs,
    input  logic [4:0]      exeRt,
    input  logic [XLEN-1:0] exeBusA,
    input  logic [XLEN-1:0] exeBusB,
    input  logic            memRegWr,
    input  logic [4:0]      memDst,
    input  logic [XLEN-1:0] memAluOut,
    input  logic            wbRegWr,
    input  logic [4:0]      wbDst,
    input  logic [XLEN-1:0] wbResult,
    output logic [XLEN-1:0] fwdA,
    output logic [XLEN-1:0] fwdB
);

    function automatic logic [XLEN-1:0] pick(input logic [4:0] src,
                                             input logic [XLEN-1:0] regVal);
        if (memRegWr && memDst != 5'd0 && memDst == src)
            return memAluOut; // newest value wins
        else if (wbRegWr && wbDst != 5'd0 && wbDst == src)
            return wbResult;
        else
            return regVal;
    endfunction

    always_comb begin
        fwdA = pick(exeRs, exeBusA);
        fwdB = pick(exeRt, exeBusB);
    end

endmodule

/* rtl/exeReg.sv */
// decode-to-execute pipeline register with flush and hold
module exeReg import exeOpsPkg::*, exeExcPkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            exeFlush,
    input  logic            hold,
    input  logic [XLEN-1:0] idPc,
    input  logic [XLEN-1:0] idBusA,
    input  logic [XLEN-1:0] idBusB,
    input  logic [XLEN-1:0] idImm32,
    input  logic [4:0]      idRs,
    input  logic [4:0]      idRt,
    input  logic [4:0]      idRd,
    input  logic [4:0]      idShamt,
    input  aluOpT           idAluOp,
    input  logic            idSrcA,
    input  logic            idSrcB,
    input  dstSelT          idDstSel,
    input  logic            idRegWr,
    input  memOpT           idMemOp,
    input  branchT          idBranch,
    input  trapT            idTrap,
    output logic [XLEN-1:0] exePc,
    output logic [XLEN-1:0] exeBusA,
    output logic [XLEN-1:0] exeBusB,
    output logic [XLEN-1:0] exeImm32,
    output logic [4:0]      exeRs,
    output logic [4:0]      exeRt,
    output logic [4:0]      exeRd,
    output logic [4:0]      exeShamt,
    output aluOpT           exeAluOp,
    output logic            exeSrcA,
    output logic            exeSrcB,
    output dstSelT          exeDstSel,
    output logic            exeRegWr,
    output memOpT           exeMemOp,
    output branchT          exeBranch,
    output trapT            exeTrap
);

    always_ff @(posedge clk) begin
        if (!hold) begin
            exePc     <= idPc;
            exeBusA   <= idBusA;
            exeBusB   <= idBusB;
            exeImm32  <= idImm32;
            exeRs     <= idRs;
            exeRt     <= idRt;
            exeRd     <= idRd;
            exeShamt  <= idShamt;
            exeSrcA   <= idSrcA;
            exeSrcB   <= idSrcB;
            exeDstSel <= idDstSel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || exeFlush) begin // flush beats hold
            exeAluOp  <= aluNop;
            exeRegWr  <= 1'b0;
            exeMemOp  <= memNone;
            exeBranch <= brNone;
            exeTrap   <= trapNone;
        end else if (!hold) begin
            exeAluOp  <= idAluOp;
            exeRegWr  <= idRegWr;
            exeMemOp  <= idMemOp;
            exeBranch <= idBranch;
            exeTrap   <= idTrap;
        end
    end

endmodule

/* rtl/exeExcPkg.sv */
// exception codes, destination select and link register number
package exeExcPkg;

    localparam logic [4:0] LINK_REG = 5'd31;

    typedef enum logic [1:0] {
        dstRd,
        dstRt,
        dstLink // writes r31
    } dstSelT;

    typedef enum logic [2:0] {
        excNone,
        excOverflow,
        excTrap,
        excAddrLoad,
        excAddrStore
    } excT;

endpackage

/* rtl/exeOpsPkg.sv */
// data width and enums for ALU, branch, trap and memory-access operations
package exeOpsPkg;

    localparam int XLEN = 32;

    typedef enum logic [4:0] {
        aluAdd,  aluAddu, aluSub,  aluSubu,
        aluAnd,  aluOr,   aluXor,  aluNor,
        aluSlt,  aluSltu,
        aluSll,  aluSrl,  aluSra,  aluLui,
        aluMult, aluMultu, aluDiv, aluDivu,
        aluMfhi, aluMflo, aluMthi, aluMtlo,
        aluNop
    } aluOpT;

    typedef enum logic [2:0] {
        brNone,
        brBeq,
        brBne,
        brBlez,
        brBgtz,
        brBltz,
        brBgez,
        brJr
    } branchT;

    typedef enum logic [3:0] {
        memNone,
        memLw, memLh, memLhu, memLb, memLbu,
        memSw, memSh, memSb
    } memOpT;

    typedef enum logic [1:0] {trapNone, trapTeq, trapTne} trapT;

endpackage
